// File: dv/core_id_tb.sv
`timescale 1ns/1ps
`include "core_config.svh"

module core_id_tb;
    import core_pkg::*;

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int PERIOD_NS       = 10;

    logic                  clock, reset;
    logic [31:0]           inst;
    logic [`CORE_XLEN-1:0] pc, pc4, ex_out, wb_data;
    logic                  stall, flush, wb_enable;
    logic [`CORE_REGW-1:0] wb_regnum;
    forward_t              forward_a, forward_b;
    id_regs_t              id_regs;

    // register contents as the testbench wrote them
    logic [`CORE_XLEN-1:0] shadow [`CORE_NREGS];
    id_regs_t prev_exp, pend_exp, exp_d;
    logic     pend_chk, chk_d;
    string    test_name, pend_name, name_d;
    int       errors, test_base, tests_passed, tests_failed;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(8)) clock_gen_inst (
        .clock(clock),
        .reset(reset)
    );

    core_id_top core_id_top_inst (
        .clock(clock), .reset(reset), .inst(inst), .pc(pc), .pc4(pc4),
        .stall(stall), .flush(flush), .forward_a(forward_a), .forward_b(forward_b),
        .ex_out(ex_out), .wb_enable(wb_enable), .wb_regnum(wb_regnum),
        .wb_data(wb_data), .id_regs(id_regs)
    );

    // an instruction driven at one edge is in id_regs after the next
    always @(posedge clock) begin
        chk_d  <= pend_chk;
        exp_d  <= pend_exp;
        name_d <= pend_name;
    end

    assert property (@(negedge clock) disable iff (reset) chk_d |-> (id_regs == exp_d))
        else begin
            $display("mismatch %s expected %h actual %h", name_d, exp_d, id_regs);
            errors++;
        end

    assert property (@(negedge clock) reset |-> (id_regs == '0))
        else begin
            $display("id_regs holds a nonzero value while reset is asserted");
            errors++;
        end

    function automatic logic [31:0] rtype(input funct_t fn, input logic [4:0] s,
                                          input logic [4:0] t, input logic [4:0] d);
        return {OP_SPECIAL, s, t, d, 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype(input opcode_t op, input logic [4:0] s,
                                          input logic [4:0] t, input logic [15:0] imm);
        return {op, s, t, imm};
    endfunction

    // expected ID/EX record for one instruction
    function automatic id_regs_t model_decode(input logic [31:0] i, input logic [63:0] pc_v,
                                              input logic [63:0] pc4_v, input forward_t fa,
                                              input forward_t fb, input logic [63:0] ex_v,
                                              input logic [63:0] wb_v);
        id_regs_t    r;
        logic [5:0]  op, fn;
        logic [4:0]  rs_n, rt_n;
        logic        sub, ign, logic_op, adder_wr;
        logic [63:0] a, b_reg, b_in, res;
        r        = '0;
        op       = i[31:26];
        fn       = i[5:0];
        rs_n     = i[25:21];
        rt_n     = i[20:16];
        sub      = 1'b0;
        ign      = 1'b0;
        logic_op = 1'b0;
        r.rs         = rs_n;
        r.rt         = rt_n;
        r.lui_imm    = i[15:0];
        r.shamt      = i[10:6];
        r.pc4        = pc4_v;
        r.w_regnum   = i[15:11];
        r.b_is_reg   = 1'b1;
        case (op)
            OP_SPECIAL: begin
                r.write_enable  = (fn == FN_DADD) || (fn == FN_DADDU) ||
                                  (fn == FN_DSUB) || (fn == FN_DSUBU);
                r.reserved_inst = !r.write_enable;
                sub             = (fn == FN_DSUB) || (fn == FN_DSUBU);
                ign             = (fn == FN_DADDU) || (fn == FN_DSUBU);
            end
            OP_DADDI, OP_DADDIU: begin
                r.write_enable = 1'b1;
                r.alu_src2     = SRC2_SIGN_IMM;
                r.w_regnum     = rt_n;
                r.b_is_reg     = 1'b0;
                ign            = (op == OP_DADDIU);
            end
            OP_ORI, OP_LUI: begin
                r.write_enable = 1'b1;
                r.alu_src2     = SRC2_ZERO_IMM;
                r.w_regnum     = rt_n;
                r.b_is_reg     = 1'b0;
                logic_op       = (op == OP_ORI);
                r.lui          = (op == OP_LUI);
            end
            OP_LD: begin
                r.write_enable = 1'b1;
                r.alu_src2     = SRC2_SIGN_IMM;
                r.w_regnum     = rt_n;
                r.b_is_reg     = 1'b0;
                r.mem_load     = LOAD_DOUBLE;
            end
            OP_SD: begin
                r.alu_src2  = SRC2_SIGN_IMM;
                r.mem_store = STORE_DOUBLE;
            end
            OP_BEQ, OP_BNE: begin
                sub            = 1'b1;
                r.control_type = CT_BRANCH;
                r.beq          = (op == OP_BEQ);
                r.bne          = (op == OP_BNE);
            end
            OP_BC: begin
                r.control_type = CT_BRANCH;
                r.bc           = 1'b1;
            end
            OP_JAL: begin
                r.write_enable = 1'b1;
                r.w_regnum     = 5'd31;
                r.b_is_reg     = 1'b0;
                r.control_type = CT_JUMP;
                r.linkpc       = 1'b1;
            end
            default: r.reserved_inst = 1'b1;
        endcase
        r.alu_op = {logic_op, 1'b0, sub};

        case (fa)
            FWD_EX:  a = ex_v;
            FWD_MEM: a = wb_v;
            default: a = shadow[rs_n];
        endcase
        b_reg = shadow[rt_n];
        if (r.b_is_reg && fb == FWD_EX) b_reg = ex_v;
        if (r.b_is_reg && fb == FWD_MEM) b_reg = wb_v;

        // previous record wrote its adder result
        adder_wr = prev_exp.write_enable && !prev_exp.alu_op[2] && !prev_exp.lui &&
                   !prev_exp.linkpc && prev_exp.mem_load == LOAD_NONE &&
                   prev_exp.w_regnum != 5'd0;
        if (adder_wr && prev_exp.w_regnum == rs_n) a = prev_exp.au_out;
        if (adder_wr && r.b_is_reg && prev_exp.w_regnum == rt_n) b_reg = prev_exp.au_out;

        case (r.alu_src2)
            SRC2_SIGN_IMM: b_in = {{48{i[15]}}, i[15:0]};
            SRC2_ZERO_IMM: b_in = {48'd0, i[15:0]};
            default:       b_in = b_reg;
        endcase
        res = sub ? a - b_in : a + b_in;

        r.a_data     = a;
        r.b_data     = (r.mem_store == STORE_DOUBLE) ? b_reg : b_in;
        r.au_out     = res;
        r.zero       = (res == 64'd0);
        r.negative   = res[63];
        r.borrow_out = sub && (a < b_in);
        if (sub) r.overflow = (a[63] != b_in[63]) && (res[63] != a[63]);
        else     r.overflow = (a[63] == b_in[63]) && (res[63] != a[63]);
        r.overflow   = r.overflow && !ign;
        r.pc_branch  = pc_v + (r.bc ? {{36{i[25]}}, i[25:0], 2'b00}
                                    : {{46{i[15]}}, i[15:0], 2'b00});
        r.jump_addr  = {32'd0, pc4_v[63:60], i[25:0], 2'b00};
        return r;
    endfunction

    // one cycle of stimulus plus its expected record
    task automatic issue(input logic [31:0] i, input forward_t fa, input forward_t fb,
                         input logic [63:0] exv, input logic wen, input logic [4:0] wnum,
                         input logic [63:0] wdat, input logic stl, input logic fl);
        logic [63:0] pc_v;
        id_regs_t    e;
        pc_v = {$urandom, $urandom} & ~64'h3;
        @(posedge clock);
        inst      <= i;
        pc        <= pc_v;
        pc4       <= pc_v + 64'd4;
        stall     <= stl;
        flush     <= fl;
        forward_a <= fa;
        forward_b <= fb;
        ex_out    <= exv;
        wb_enable <= wen;
        wb_regnum <= wnum;
        wb_data   <= wdat;
        if (stl || fl) e = '0;
        else e = model_decode(i, pc_v, pc_v + 64'd4, fa, fb, exv, wdat);
        prev_exp = e;
        if (wen && wnum != 5'd0) shadow[wnum] = wdat;
        pend_exp  <= e;
        pend_chk  <= 1'b1;
        pend_name <= test_name;
    endtask

    task automatic run_inst(input logic [31:0] i);
        issue(i, FWD_NONE, FWD_NONE, '0, 1'b0, 5'd0, '0, 1'b0, 1'b0);
    endtask

    task automatic bubble();
        issue($urandom, FWD_NONE, FWD_NONE, '0, 1'b0, 5'd0, '0, 1'b1, 1'b0);
    endtask

    task automatic write_reg(input logic [4:0] n, input logic [63:0] v);
        issue($urandom, FWD_NONE, FWD_NONE, '0, 1'b1, n, v, 1'b1, 1'b0);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_base = errors;
    endtask

    task automatic finish_test();
        int n;
        bubble();
        repeat (2) @(posedge clock);
        n = errors - test_base;
        if (n == 0) begin
            tests_passed++;
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, n);
        end
    endtask

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * PERIOD_NS);
        $display("watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h7fe19e15));
        inst      = '0;
        pc        = '0;
        pc4       = '0;
        stall     = 1'b1;
        flush     = 1'b0;
        forward_a = FWD_NONE;
        forward_b = FWD_NONE;
        ex_out    = '0;
        wb_enable = 1'b0;
        wb_regnum = '0;
        wb_data   = '0;
        pend_chk  = 1'b0;
        pend_exp  = '0;
        pend_name = "";
        prev_exp  = '0;
        errors    = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int n = 0; n < `CORE_NREGS; n++) shadow[n] = '0;

        start_test("reset_bubbles");
        wait (reset == 1'b0);
        bubble();
        issue($urandom, FWD_NONE, FWD_NONE, '0, 1'b0, 5'd0, '0, 1'b0, 1'b1);
        run_inst(rtype(FN_DADDU, 1, 2, 3));
        issue(rtype(FN_DSUBU, 3, 3, 4), FWD_NONE, FWD_NONE, '0, 1'b0, 5'd0, '0, 1'b1, 1'b0);
        issue(itype(OP_LD, 2, 5, 16'h0008), FWD_EX, FWD_NONE, '0, 1'b0, 5'd0, '0, 1'b0, 1'b1);
        finish_test();

        start_test("arith");
        for (int n = 1; n < 9; n++) write_reg(5'(n), {$urandom, $urandom});
        write_reg(10, 64'h7fff_ffff_ffff_fff0);
        write_reg(11, 64'h0000_0000_0000_0100);
        write_reg(0, {$urandom, $urandom});
        run_inst(rtype(FN_DADDU, 1, 2, 20));
        run_inst(rtype(FN_DSUBU, 3, 4, 21));
        run_inst(rtype(FN_DADD, 5, 6, 22));
        run_inst(rtype(FN_DSUB, 7, 8, 23));
        run_inst(rtype(FN_DADD, 10, 11, 24));
        run_inst(rtype(FN_DADDU, 10, 11, 25));
        run_inst(rtype(FN_DADDU, 0, 1, 26));
        finish_test();

        start_test("imm_mem");
        run_inst(itype(OP_DADDIU, 1, 15, 16'hfffb));
        run_inst(itype(OP_DADDI, 2, 16, 16'h8001));
        run_inst(itype(OP_ORI, 3, 17, 16'hf0f0));
        run_inst(itype(OP_LUI, 0, 18, 16'h1234));
        run_inst(itype(OP_SD, 5, 4, 16'hfff8));
        run_inst(itype(OP_LD, 5, 19, 16'h0010));
        finish_test();

        start_test("forwarding");
        issue(rtype(FN_DADDU, 1, 2, 20), FWD_EX, FWD_NONE, {$urandom, $urandom},
              1'b0, 5'd0, '0, 1'b0, 1'b0);
        issue(rtype(FN_DADDU, 3, 4, 21), FWD_NONE, FWD_EX, {$urandom, $urandom},
              1'b0, 5'd0, '0, 1'b0, 1'b0);
        issue(rtype(FN_DADDU, 3, 4, 22), FWD_MEM, FWD_MEM, '0, 1'b1, 5'd3,
              {$urandom, $urandom}, 1'b0, 1'b0);
        issue(itype(OP_SD, 5, 6, 16'h0008), FWD_NONE, FWD_MEM, '0, 1'b1, 5'd6,
              {$urandom, $urandom}, 1'b0, 1'b0);
        run_inst(rtype(FN_DADDU, 1, 2, 23));
        run_inst(rtype(FN_DADDU, 23, 23, 24));
        run_inst(rtype(FN_DSUBU, 24, 1, 25));
        finish_test();

        start_test("control_flow");
        for (int k = 0; k < 4; k++) begin
            run_inst(itype(OP_BEQ, 1, 2, 16'($urandom)));
            run_inst(itype(OP_BNE, 3, 4, 16'($urandom)));
            run_inst({OP_BC, 26'($urandom)});
            run_inst({OP_JAL, 26'($urandom)});
        end
        finish_test();

        start_test("reserved");
        run_inst({6'h3b, 26'($urandom)});
        run_inst({6'h01, 26'($urandom)});
        run_inst({6'h00, 20'($urandom), 6'h20});
        finish_test();

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
                 errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end
endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clock,
    output logic reset
);
    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end
endmodule

// File: filelist.f
+incdir+hdl
hdl/core_pkg.sv
hdl/regfile_if.sv
hdl/mips_decoder.sv
hdl/regfile.sv
hdl/au.sv
hdl/core_id.sv
hdl/core_id_top.sv
dv/tb_clock_gen.sv
dv/core_id_tb.sv

// File: hdl/au.sv
`timescale 1ns/1ps
`include "core_config.svh"

module au (
    input  logic [`CORE_XLEN-1:0] a,
    input  logic [`CORE_XLEN-1:0] b,
    input  logic                  sub,
    output logic [`CORE_XLEN-1:0] out,
    output logic                  overflow,
    output logic                  zero,
    output logic                  negative,
    output logic                  borrow_out
);
    localparam int MSB = `CORE_XLEN - 1;

    logic [`CORE_XLEN-1:0] b_eff;
    logic [`CORE_XLEN:0]   sum;

    // subtract as a + ~b + 1
    assign b_eff = sub ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, b_eff} + {{`CORE_XLEN{1'b0}}, sub};
    assign out   = sum[MSB:0];

    // same operand signs but a different result sign
    assign overflow   = (a[MSB] == b_eff[MSB]) && (out[MSB] != a[MSB]);
    assign zero       = (out == '0);
    assign negative   = out[MSB];
    assign borrow_out = sub & ~sum[`CORE_XLEN];
endmodule

// File: hdl/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath width of the core
`define CORE_XLEN 64

// architectural register file size
`define CORE_NREGS 32

// bits needed to name one register
`define CORE_REGW 5

`endif

// File: hdl/core_id.sv
`timescale 1ns/1ps
`include "core_config.svh"

module core_id (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [31:0]           inst,
    input  logic [`CORE_XLEN-1:0] pc,
    input  logic [`CORE_XLEN-1:0] pc4,
    input  logic                  stall,
    input  logic                  flush,
    input  core_pkg::forward_t    forward_a,
    input  core_pkg::forward_t    forward_b,
    input  logic [`CORE_XLEN-1:0] ex_out,
    regfile_if.stage              rf,
    output core_pkg::id_regs_t    id_regs
);
    import core_pkg::*;

    logic [`CORE_REGW-1:0] rs, rt, rd, w_regnum;
    logic [2:0]            alu_op;
    alu_src2_t             alu_src2;
    rd_src_t               rd_src;
    control_type_t         control_type;
    mem_load_t             mem_load;
    mem_store_t            mem_store;
    logic write_enable, lui, linkpc, beq, bne, bc, bal, ignore_overflow, reserved_inst;
    logic b_is_reg, prev_au_write, bypass_a, bypass_b;
    logic [`CORE_XLEN-1:0] fwd_a, fwd_b, a_op, b_reg, b_in, au_out;
    logic [`CORE_XLEN-1:0] sign_imm, zero_imm, branch_off, bc_off, jump_addr;
    logic overflow, zero, negative, borrow_out;
    id_regs_t id_next;

    mips_decoder decoder_inst (
        .inst(inst), .rs(rs), .rt(rt), .rd(rd),
        .alu_op(alu_op), .alu_src2(alu_src2), .rd_src(rd_src),
        .control_type(control_type), .mem_load(mem_load), .mem_store(mem_store),
        .write_enable(write_enable), .lui(lui), .linkpc(linkpc),
        .beq(beq), .bne(bne), .bc(bc), .bal(bal),
        .ignore_overflow(ignore_overflow), .reserved_inst(reserved_inst)
    );

    assign rf.rs    = rs;
    assign rf.rt    = rt;
    assign b_is_reg = (rd_src == RDSRC_RD);

    always_comb begin
        case (rd_src)
            RDSRC_RT:   w_regnum = rt;
            RDSRC_LINK: w_regnum = `CORE_REGW'(31);
            default:    w_regnum = rd;
        endcase
    end

    // hazard unit forwarding
    always_comb begin
        case (forward_a)
            FWD_EX:  fwd_a = ex_out;
            FWD_MEM: fwd_a = rf.wb_data;
            default: fwd_a = rf.a_data;
        endcase
        case (b_is_reg ? forward_b : FWD_NONE)
            FWD_EX:  fwd_b = ex_out;
            FWD_MEM: fwd_b = rf.wb_data;
            default: fwd_b = rf.b_data;
        endcase
    end

    // previous record wrote an adder result that is already known here
    assign prev_au_write = id_regs.write_enable && !id_regs.alu_op[2] && !id_regs.lui &&
                           !id_regs.linkpc && (id_regs.mem_load == LOAD_NONE) &&
                           (id_regs.w_regnum != '0);
    assign bypass_a = prev_au_write && (id_regs.w_regnum == rs);
    assign bypass_b = prev_au_write && b_is_reg && (id_regs.w_regnum == rt);

    assign a_op  = bypass_a ? id_regs.au_out : fwd_a;
    assign b_reg = bypass_b ? id_regs.au_out : fwd_b;

    assign sign_imm = {{(`CORE_XLEN-16){inst[15]}}, inst[15:0]};
    assign zero_imm = {{(`CORE_XLEN-16){1'b0}}, inst[15:0]};

    always_comb begin
        case (alu_src2)
            SRC2_SIGN_IMM: b_in = sign_imm;
            SRC2_ZERO_IMM: b_in = zero_imm;
            default:       b_in = b_reg;
        endcase
    end

    au au_inst (
        .a(a_op), .b(b_in), .sub(alu_op[0]), .out(au_out),
        .overflow(overflow), .zero(zero), .negative(negative), .borrow_out(borrow_out)
    );

    assign branch_off = {{(`CORE_XLEN-18){inst[15]}}, inst[15:0], 2'b00};
    assign bc_off     = {{(`CORE_XLEN-28){inst[25]}}, inst[25:0], 2'b00};
    assign jump_addr  = {{(`CORE_XLEN-32){1'b0}}, pc4[`CORE_XLEN-1 -: 4], inst[25:0], 2'b00};

    always_comb begin
        id_next               = '0;
        id_next.w_regnum      = w_regnum;
        id_next.write_enable  = write_enable;
        id_next.alu_op        = alu_op;
        id_next.alu_src2      = alu_src2;
        id_next.control_type  = control_type;
        id_next.mem_load      = mem_load;
        id_next.mem_store     = mem_store;
        id_next.lui           = lui;
        id_next.linkpc        = linkpc;
        id_next.beq           = beq;
        id_next.bne           = bne;
        id_next.bc            = bc;
        id_next.bal           = bal;
        id_next.reserved_inst = reserved_inst;
        id_next.a_data        = a_op;
        // stores carry the raw rt value as write data
        id_next.b_data        = (mem_store == STORE_DOUBLE) ? b_reg : b_in;
        id_next.au_out        = au_out;
        id_next.zero          = zero;
        id_next.negative      = negative;
        id_next.borrow_out    = borrow_out;
        id_next.overflow      = overflow & ~ignore_overflow;
        id_next.lui_imm       = inst[15:0];
        id_next.shamt         = inst[10:6];
        id_next.rs            = rs;
        id_next.rt            = rt;
        id_next.pc4           = pc4;
        id_next.pc_branch     = pc + (bc ? bc_off : branch_off);
        id_next.jump_addr     = jump_addr;
        id_next.b_is_reg      = b_is_reg;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            id_regs <= '0;
        end else if (stall || flush) begin
            // bubble
            id_regs <= '0;
        end else begin
            id_regs <= id_next;
        end
    end
endmodule

// File: hdl/core_id_top.sv
`timescale 1ns/1ps
`include "core_config.svh"

module core_id_top (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [31:0]           inst,
    input  logic [`CORE_XLEN-1:0] pc,
    input  logic [`CORE_XLEN-1:0] pc4,
    input  logic                  stall,
    input  logic                  flush,
    input  core_pkg::forward_t    forward_a,
    input  core_pkg::forward_t    forward_b,
    input  logic [`CORE_XLEN-1:0] ex_out,
    input  logic                  wb_enable,
    input  logic [`CORE_REGW-1:0] wb_regnum,
    input  logic [`CORE_XLEN-1:0] wb_data,
    output core_pkg::id_regs_t    id_regs
);
    regfile_if rf_bus ();

    // writeback port comes straight from the pins
    assign rf_bus.wb_enable = wb_enable;
    assign rf_bus.wb_regnum = wb_regnum;
    assign rf_bus.wb_data   = wb_data;

    core_id core_id_inst (
        .clock(clock),
        .reset(reset),
        .inst(inst),
        .pc(pc),
        .pc4(pc4),
        .stall(stall),
        .flush(flush),
        .forward_a(forward_a),
        .forward_b(forward_b),
        .ex_out(ex_out),
        .rf(rf_bus.stage),
        .id_regs(id_regs)
    );

    regfile regfile_inst (
        .clock(clock),
        .reset(reset),
        .rf(rf_bus.file)
    );
endmodule

// File: hdl/core_pkg.sv
`include "core_config.svh"

package core_pkg;

    // primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_DADDI   = 6'h18,
        OP_DADDIU  = 6'h19,
        OP_BC      = 6'h32,
        OP_LD      = 6'h37,
        OP_SD      = 6'h3f
    } opcode_t;

    // function field under SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        FN_DADD  = 6'h2c,
        FN_DADDU = 6'h2d,
        FN_DSUB  = 6'h2e,
        FN_DSUBU = 6'h2f
    } funct_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_EX   = 2'd1,
        FWD_MEM  = 2'd2
    } forward_t;

    typedef enum logic [1:0] {
        SRC2_REG      = 2'd0,
        SRC2_SIGN_IMM = 2'd1,
        SRC2_ZERO_IMM = 2'd2
    } alu_src2_t;

    typedef enum logic [1:0] {
        RDSRC_RD   = 2'd0,
        RDSRC_RT   = 2'd1,
        RDSRC_LINK = 2'd2
    } rd_src_t;

    typedef enum logic [1:0] {
        CT_SEQ    = 2'd0,
        CT_BRANCH = 2'd1,
        CT_JUMP   = 2'd2
    } control_type_t;

    typedef enum logic {
        LOAD_NONE   = 1'b0,
        LOAD_DOUBLE = 1'b1
    } mem_load_t;

    typedef enum logic {
        STORE_NONE   = 1'b0,
        STORE_DOUBLE = 1'b1
    } mem_store_t;

    // ID/EX pipeline record
    typedef struct packed {
        logic [`CORE_REGW-1:0] w_regnum;
        logic                  write_enable;
        logic [2:0]            alu_op;
        alu_src2_t             alu_src2;
        control_type_t         control_type;
        mem_load_t             mem_load;
        mem_store_t            mem_store;
        logic                  lui;
        logic                  linkpc;
        logic                  beq;
        logic                  bne;
        logic                  bc;
        logic                  bal;
        logic                  reserved_inst;
        logic [`CORE_XLEN-1:0] a_data;
        logic [`CORE_XLEN-1:0] b_data;
        logic [`CORE_XLEN-1:0] au_out;
        logic                  zero;
        logic                  negative;
        logic                  borrow_out;
        logic                  overflow;
        logic [15:0]           lui_imm;
        logic [4:0]            shamt;
        logic [`CORE_REGW-1:0] rs;
        logic [`CORE_REGW-1:0] rt;
        logic [`CORE_XLEN-1:0] pc4;
        logic [`CORE_XLEN-1:0] pc_branch;
        logic [`CORE_XLEN-1:0] jump_addr;
        logic                  b_is_reg;
    } id_regs_t;

endpackage

// File: hdl/mips_decoder.sv
`timescale 1ns/1ps
`include "core_config.svh"

module mips_decoder (
    input  logic [31:0]                inst,
    output logic [`CORE_REGW-1:0]      rs,
    output logic [`CORE_REGW-1:0]      rt,
    output logic [`CORE_REGW-1:0]      rd,
    output logic [2:0]                 alu_op,
    output core_pkg::alu_src2_t        alu_src2,
    output core_pkg::rd_src_t          rd_src,
    output core_pkg::control_type_t    control_type,
    output core_pkg::mem_load_t        mem_load,
    output core_pkg::mem_store_t       mem_store,
    output logic                       write_enable,
    output logic                       lui,
    output logic                       linkpc,
    output logic                       beq,
    output logic                       bne,
    output logic                       bc,
    output logic                       bal,
    output logic                       ignore_overflow,
    output logic                       reserved_inst
);
    import core_pkg::*;

    // alu_op encodings: bit 2 picks the logic unit, bit 0 means subtract
    localparam logic [2:0] ALU_ADD = 3'b000;
    localparam logic [2:0] ALU_SUB = 3'b001;
    localparam logic [2:0] ALU_OR  = 3'b100;

    opcode_t opcode;
    funct_t  funct;

    assign opcode = opcode_t'(inst[31:26]);
    assign funct  = funct_t'(inst[5:0]);

    assign rs = inst[25:21];
    assign rt = inst[20:16];
    assign rd = inst[15:11];

    always_comb begin
        alu_op          = ALU_ADD;
        alu_src2        = SRC2_REG;
        rd_src          = RDSRC_RD;
        control_type    = CT_SEQ;
        mem_load        = LOAD_NONE;
        mem_store       = STORE_NONE;
        write_enable    = 1'b0;
        lui             = 1'b0;
        linkpc          = 1'b0;
        beq             = 1'b0;
        bne             = 1'b0;
        bc              = 1'b0;
        bal             = 1'b0;
        ignore_overflow = 1'b0;
        reserved_inst   = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_DADD: begin
                        write_enable = 1'b1;
                    end
                    FN_DADDU: begin
                        write_enable    = 1'b1;
                        ignore_overflow = 1'b1;
                    end
                    FN_DSUB: begin
                        write_enable = 1'b1;
                        alu_op       = ALU_SUB;
                    end
                    FN_DSUBU: begin
                        write_enable    = 1'b1;
                        alu_op          = ALU_SUB;
                        ignore_overflow = 1'b1;
                    end
                    default: reserved_inst = 1'b1;
                endcase
            end
            OP_DADDI, OP_DADDIU: begin
                write_enable    = 1'b1;
                alu_src2        = SRC2_SIGN_IMM;
                rd_src          = RDSRC_RT;
                ignore_overflow = (opcode == OP_DADDIU);
            end
            OP_ORI: begin
                write_enable = 1'b1;
                alu_op       = ALU_OR;
                alu_src2     = SRC2_ZERO_IMM;
                rd_src       = RDSRC_RT;
            end
            OP_LUI: begin
                write_enable = 1'b1;
                alu_src2     = SRC2_ZERO_IMM;
                rd_src       = RDSRC_RT;
                lui          = 1'b1;
            end
            OP_LD: begin
                write_enable = 1'b1;
                alu_src2     = SRC2_SIGN_IMM;
                rd_src       = RDSRC_RT;
                mem_load     = LOAD_DOUBLE;
            end
            OP_SD: begin
                // rd_src stays RD so rt is still read as store data
                alu_src2  = SRC2_SIGN_IMM;
                mem_store = STORE_DOUBLE;
            end
            OP_BEQ, OP_BNE: begin
                alu_op       = ALU_SUB;
                control_type = CT_BRANCH;
                beq          = (opcode == OP_BEQ);
                bne          = (opcode == OP_BNE);
            end
            OP_BC: begin
                control_type = CT_BRANCH;
                bc           = 1'b1;
            end
            OP_JAL: begin
                write_enable = 1'b1;
                rd_src       = RDSRC_LINK;
                control_type = CT_JUMP;
                linkpc       = 1'b1;
            end
            default: reserved_inst = 1'b1;
        endcase
    end
endmodule

// File: hdl/regfile.sv
`timescale 1ns/1ps
`include "core_config.svh"

module regfile (
    input logic clock,
    input logic reset,
    regfile_if.file rf
);
    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (rf.wb_enable && (rf.wb_regnum != '0)) begin
            // register 0 is never written, so it reads as zero
            regs[rf.wb_regnum] <= rf.wb_data;
        end
    end

    // no write-through, same-cycle writes come in through the forward path
    assign rf.a_data = regs[rf.rs];
    assign rf.b_data = regs[rf.rt];
endmodule

// File: hdl/regfile_if.sv
`timescale 1ns/1ps
`include "core_config.svh"

interface regfile_if;
    // read side
    logic [`CORE_REGW-1:0] rs;
    logic [`CORE_REGW-1:0] rt;
    logic [`CORE_XLEN-1:0] a_data;
    logic [`CORE_XLEN-1:0] b_data;

    // write side, from writeback
    logic                  wb_enable;
    logic [`CORE_REGW-1:0] wb_regnum;
    logic [`CORE_XLEN-1:0] wb_data;

    // decode stage also taps wb_data for the FROM_MEM forward
    modport stage (
        output rs,
        output rt,
        input  a_data,
        input  b_data,
        input  wb_data
    );

    modport file (
        input  rs,
        input  rt,
        output a_data,
        output b_data,
        input  wb_enable,
        input  wb_regnum,
        input  wb_data
    );

    modport writer (
        output wb_enable,
        output wb_regnum,
        output wb_data
    );
endinterface

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module core_id_tb -Mdir obj_dir

out=$(./obj_dir/Vcore_id_tb)
echo "$out"

if echo "$out" | grep -qx "All tests passed"; then
    exit 0
else
    exit 1
fi
